//--- common/masked_types_pkg.sv
// Arithmetic share types for the masked datapath
// Holds the share width, the two-share word struct and the helpers
// that add, re-randomise and recombine two-share words

package masked_types_pkg;

    // ==============================
    // Widths
    // ==============================
    localparam int DATA_W = 16; // Bits per share, all arithmetic is modulo 2^DATA_W

    // ==============================
    // Two-share word
    // ==============================
    // Field order puts s0 in the low half so the packed layout matches a
    // [1:0][DATA_W-1:0] share array with index 0 at the bottom
    typedef struct packed {
        logic [DATA_W-1:0] s1; // Second arithmetic share
        logic [DATA_W-1:0] s0; // First arithmetic share
    } share_pair_t;

    // Share-wise sum, the unmasked values add without ever being formed
    function automatic share_pair_t share_add(share_pair_t a, share_pair_t b);
        share_pair_t r;
        r.s0 = a.s0 + b.s0;
        r.s1 = a.s1 + b.s1;
        return r;
    endfunction

    // Moves a fresh mask from one share to the other, unmasked value is unchanged
    function automatic share_pair_t share_refresh(share_pair_t a, logic [DATA_W-1:0] m);
        share_pair_t r;
        r.s0 = a.s0 + m; // Mask goes in on share 0
        r.s1 = a.s1 - m; // And comes out of share 1
        return r;
    endfunction

    // Recombines both shares into the plain value
    function automatic logic [DATA_W-1:0] share_unmask(share_pair_t a);
        return a.s0 + a.s1;
    endfunction

endpackage

//--- common/mac_ctrl_pkg.sv
// Control side of the masked dot-product pipeline
// Holds the run tag width and the control struct that travels
// next to the data shares from input to accumulator

package mac_ctrl_pkg;

    // ==============================
    // Widths
    // ==============================
    localparam int TAG_W = 4; // Run identifier handed back with each result

    // ==============================
    // Per-term control
    // ==============================
    // One of these accompanies every term. A run is the terms from one with
    // start set to one with last set, both may sit on the same term
    typedef struct packed {
        logic             valid; // Term carries data, low cycles are idle
        logic             start; // First term of a run, reloads the accumulator
        logic             last;  // Final term of a run, triggers the output
        logic [TAG_W-1:0] tag;   // Run tag, sampled from the last term
    } mac_ctrl_t;

    // Total is 7 bits, handy when checking pipeline register counts
    localparam int MAC_CTRL_W = $bits(mac_ctrl_t);

endpackage

//--- hdl/masked_mult/masked_mult_two_share.sv
// Two-share arithmetic masked multiplier
// Stage 1 forms the four share cross products and masks the mixed terms
// Stage 2 folds them into two output shares with a latency of two cycles

`timescale 1ns/1ps

module masked_mult_two_share #(
    parameter int WIDTH = 16                  // Bits per share
) (
    input  logic                  clk,
    input  logic                  rst_n,      // Synchronous active-low reset
    input  logic                  zeroize,    // Clears both stages
    input  logic [WIDTH-1:0]      random,     // Fresh mask word for every cycle
    input  logic [1:0][WIDTH-1:0] x,          // Arithmetic shares of x
    input  logic [1:0][WIDTH-1:0] y,          // Arithmetic shares of y
    output logic [1:0][WIDTH-1:0] z           // Arithmetic shares of x times y
);

    // ==============================
    // Stage 1 cross products
    // ==============================
    logic [WIDTH-1:0] prod_00;                // x0 * y0
    logic [WIDTH-1:0] prod_01;                // x0 * y1
    logic [WIDTH-1:0] prod_10;                // x1 * y0
    logic [WIDTH-1:0] prod_11;                // x1 * y1

    logic [WIDTH-1:0] direct_q [2];           // Registered same-index products
    logic [WIDTH-1:0] mixed_q  [2];           // Registered mixed products with mask

    always_comb begin
        prod_00 = WIDTH'(x[0] * y[0]);
        prod_01 = WIDTH'(x[0] * y[1]);
        prod_10 = WIDTH'(x[1] * y[0]);
        prod_11 = WIDTH'(x[1] * y[1]);
    end

    // The mixed products combine both shares of a secret, so they are never
    // stored without the mask. The mask cancels when z0 and z1 are summed
    always_ff @(posedge clk) begin
        if (!rst_n || zeroize) begin
            for (int i = 0; i < 2; i++) begin
                direct_q[i] <= '0;
                mixed_q[i]  <= '0;
            end
        end else begin
            direct_q[0] <= prod_00;
            direct_q[1] <= prod_11;
            mixed_q[0]  <= prod_01 + random;   // Mask added on share 0
            mixed_q[1]  <= prod_10 - random;   // Same mask removed on share 1
        end
    end

    // ==============================
    // Stage 2 output shares
    // ==============================
    logic [WIDTH-1:0] fold [2];

    // Each output share only ever sees one masked mixed term
    always_comb begin
        fold[0] = direct_q[0] + mixed_q[0];
        fold[1] = direct_q[1] + mixed_q[1];
    end

    always_ff @(posedge clk) begin
        if (!rst_n || zeroize) begin
            z <= '0;
        end else begin
            z[0] <= fold[0];
            z[1] <= fold[1];
        end
    end

    // Algebra behind the two output shares
    // z0 + z1 = x0y0 + x0y1 + x1y0 + x1y1 = (x0 + x1)(y0 + y1) mod 2^WIDTH

endmodule

//--- hdl/pipe_delay.sv
// Register delay line for an arbitrary packed payload
// Keeps side information in step with a fixed-latency datapath

`timescale 1ns/1ps

module pipe_delay #(
    parameter int  DEPTH = 2,         // Number of register stages, at least one
    parameter type T     = logic      // Payload type, any packed type
) (
    input  logic clk,
    input  logic rst_n,               // Synchronous, active low
    input  logic zeroize,             // Drops everything in flight
    input  T     din,                 // Sampled every cycle
    output T     dout                 // din from DEPTH edges earlier
);

    // ==============================
    // Register chain
    // ==============================
    T stage [DEPTH];                  // stage[0] is nearest the input

    // Clearing every stage matters here, a stale valid bit left in the
    // chain after zeroize would complete a run that no longer exists
    always_ff @(posedge clk) begin
        if (!rst_n || zeroize) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage[i] <= '0;
            end
        end else begin
            stage[0] <= din;
            for (int i = 1; i < DEPTH; i++) begin
                stage[i] <= stage[i-1]; // Shift one step per cycle
            end
        end
    end

    assign dout = stage[DEPTH-1];

    // With DEPTH of 1 the loop above has no iterations and the chain is
    // just stage[0], which still gives a one-cycle delay

endmodule

//--- hdl/mask_prng.sv
// Mask generator for the masked datapath
// A 32-bit Galois LFSR stepped twice per cycle, split into two
// disjoint mask words so each consumer sees fresh bits every cycle

`timescale 1ns/1ps

module mask_prng
    import masked_types_pkg::*;
#(
    parameter logic [31:0] SEED = 32'h1d87_2b41 // Must be nonzero or the LFSR sticks at zero
) (
    input  logic              clk,
    input  logic              rst_n,     // Synchronous, active low
    input  logic              zeroize,   // Reloads SEED
    output logic [DATA_W-1:0] r_mult,    // Mask for the multiplier
    output logic [DATA_W-1:0] r_refresh  // Mask for the output refresh
);

    // ==============================
    // LFSR
    // ==============================
    // Feedback polynomial x^32 + x^22 + x^2 + x + 1, in right-shift Galois form
    localparam logic [31:0] TAPS = 32'h8020_0003;

    logic [31:0] state;
    logic [31:0] state_nxt;

    // One Galois step, the bit shifted out toggles the tap positions
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        logic [31:0] r;
        r = s >> 1;
        if (s[0]) begin
            r = r ^ TAPS;
        end
        return r;
    endfunction

    // Two steps per cycle so successive words overlap less
    assign state_nxt = lfsr_step(lfsr_step(state));

    always_ff @(posedge clk) begin
        if (!rst_n || zeroize) begin
            state <= SEED;
        end else begin
            state <= state_nxt;
        end
    end

    // Low and high halves go to different consumers, never the same bits
    assign r_mult    = state[DATA_W-1:0];
    assign r_refresh = state[2*DATA_W-1:DATA_W];

endmodule

//--- hdl/masked_accum/masked_accum.sv
// Share-wise run accumulator for the masked dot product
// Sums product shares over a run marked by start and last,
// then re-randomises the finished sum and presents it with its tag

`timescale 1ns/1ps

module masked_accum
    import masked_types_pkg::*, mac_ctrl_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,     // Synchronous, active low
    input  logic              zeroize,   // Clears the run and the output
    input  share_pair_t       prod,      // Product shares from the multiplier
    input  mac_ctrl_t         ctrl,      // Control aligned with prod
    input  logic [DATA_W-1:0] r_refresh, // Fresh mask for the output
    output share_pair_t       out_sum,   // Re-randomised run sum
    output logic [TAG_W-1:0]  out_tag,   // Tag of the run in out_sum
    output logic              out_valid  // One-cycle pulse per finished run
);

    // ==============================
    // Accumulate stage
    // ==============================
    share_pair_t      acc;               // Running sum, still two shares
    share_pair_t      term_sum;          // Value acc takes on a valid term
    logic             done_q;            // acc holds a finished run
    logic [TAG_W-1:0] done_tag;          // Tag of that run

    // A start term drops whatever was in acc, so a start right after a last
    // begins cleanly and a start-and-last term is a one-term run
    always_comb begin
        if (ctrl.start) begin
            term_sum = prod;
        end else begin
            term_sum = share_add(acc, prod);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || zeroize) begin
            acc      <= '0;
            done_q   <= 1'b0;
            done_tag <= '0;
        end else begin
            done_q <= ctrl.valid && ctrl.last;
            if (ctrl.valid) begin
                acc <= term_sum;         // Idle cycles leave acc alone
            end
            if (ctrl.valid && ctrl.last) begin
                done_tag <= ctrl.tag;
            end
        end
    end

    // ==============================
    // Output stage
    // ==============================
    // The finished sum is read out of acc one edge after the last term,
    // by which time acc may already hold the first term of the next run.
    // Nonblocking updates mean the old value is the one captured here
    always_ff @(posedge clk) begin
        if (!rst_n || zeroize) begin
            out_sum   <= '0;
            out_tag   <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= done_q;         // Pulse lasts exactly one cycle
            if (done_q) begin
                out_sum <= share_refresh(acc, r_refresh); // Fresh mask on the way out
                out_tag <= done_tag;
            end
        end
    end

    // out_sum and out_tag keep their value between pulses, so a slow
    // consumer can still read them until the next run finishes

endmodule

//--- hdl/masked_dot_top.sv
// Masked dot-product unit, top level
// Wires the mask generator, the two-share multiplier, the control
// delay line and the run accumulator together

`timescale 1ns/1ps

module masked_dot_top
    import masked_types_pkg::*, mac_ctrl_pkg::*;
#(
    parameter logic [31:0] SEED     = 32'h1d87_2b41, // LFSR seed for the masks
    parameter int          MULT_LAT = 2              // Must match the multiplier latency
) (
    input  logic             clk,
    input  logic             rst_n,     // Synchronous, active low
    input  logic             zeroize,   // Clears every stage, one cycle is enough
    input  share_pair_t      in_x,      // Shares of the x operand
    input  share_pair_t      in_y,      // Shares of the y operand
    input  mac_ctrl_t        in_ctrl,   // Valid, run markers and tag for this term
    output share_pair_t      out_sum,   // Shares of the finished dot product
    output logic [TAG_W-1:0] out_tag,   // Tag of the finished run
    output logic             out_valid  // One-cycle pulse per run
);

    // ==============================
    // Internal wires
    // ==============================
    logic [DATA_W-1:0]      r_mult;     // Multiplier mask
    logic [DATA_W-1:0]      r_refresh;  // Output refresh mask
    logic [1:0][DATA_W-1:0] z;          // Product shares as an array
    share_pair_t            prod;       // Same shares as a struct
    mac_ctrl_t              ctrl_d;     // in_ctrl aligned with z

    assign prod = '{s0: z[0], s1: z[1]};

    mask_prng #(
        .SEED      (SEED)
    ) u_prng (
        .clk       (clk),
        .rst_n     (rst_n),
        .zeroize   (zeroize),
        .r_mult    (r_mult),
        .r_refresh (r_refresh)
    );

    // Share 0 sits at array index 0 on both operands
    masked_mult_two_share #(
        .WIDTH   (DATA_W)
    ) u_mult (
        .clk     (clk),
        .rst_n   (rst_n),
        .zeroize (zeroize),
        .random  (r_mult),
        .x       ({in_x.s1, in_x.s0}),
        .y       ({in_y.s1, in_y.s0}),
        .z       (z)
    );

    pipe_delay #(
        .DEPTH   (MULT_LAT),
        .T       (mac_ctrl_t)
    ) u_ctrl_delay (
        .clk     (clk),
        .rst_n   (rst_n),
        .zeroize (zeroize),
        .din     (in_ctrl),
        .dout    (ctrl_d)
    );

    masked_accum u_accum (
        .clk       (clk),
        .rst_n     (rst_n),
        .zeroize   (zeroize),
        .prod      (prod),
        .ctrl      (ctrl_d),
        .r_refresh (r_refresh),
        .out_sum   (out_sum),
        .out_tag   (out_tag),
        .out_valid (out_valid)
    );

endmodule

//--- verification/tb_helpers.svh
// Testbench helpers for the masked dot-product unit
// Fibonacci LFSR for stimulus, share splitting and the reference dot product

`ifndef TB_HELPERS_SVH
`define TB_HELPERS_SVH

localparam int MAX_TERMS = 8; // Longest run the stimulus builds

// ==============================
// Stimulus LFSR
// ==============================
logic [31:0] lfsr_state = 32'hea08; // Seeded once at time zero

// One Fibonacci step per bit taken, taps at 32 22 2 1
function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
        fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        r          = {r[30:0], fb}; // Newest bit lands at the bottom
    end
    return r;
endfunction

// A full random operand word
function automatic logic [DATA_W-1:0] rand_word();
    return DATA_W'(take_bits(DATA_W));
endfunction

// Splits a plain value into two arithmetic shares with a random first share
task automatic split_shares(input logic [DATA_W-1:0] v, output share_pair_t p);
    logic [DATA_W-1:0] mask;
    mask = rand_word();
    p.s0 = mask;
    p.s1 = v - mask; // Both shares add back to v modulo 2^DATA_W
endtask

// ==============================
// Reference model
// ==============================
// Sum of the term products, every step truncated to the share width
function automatic logic [DATA_W-1:0] dot_ref(input logic [DATA_W-1:0] xs [MAX_TERMS],
                                              input logic [DATA_W-1:0] ys [MAX_TERMS],
                                              input int n);
    logic [DATA_W-1:0]   acc;
    logic [2*DATA_W-1:0] p;
    acc = '0;
    for (int i = 0; i < n; i++) begin
        p   = xs[i] * ys[i];        // Full width product first
        acc = acc + p[DATA_W-1:0];  // Then only the low half counts
    end
    return acc;
endfunction

`endif

//--- verification/tb_masked_dot.sv
// Testbench for the masked dot-product unit
// Clock and reset, run stimulus, a result checking process and the summary

`timescale 1ns/1ps

module tb_masked_dot
    import masked_types_pkg::*, mac_ctrl_pkg::*;
();

    localparam int TIMEOUT = 40; // Cycles allowed for any single wait

    logic             clk;
    logic             rst_n;
    logic             zeroize;
    share_pair_t      in_x;
    share_pair_t      in_y;
    mac_ctrl_t        in_ctrl;
    share_pair_t      out_sum;
    logic [TAG_W-1:0] out_tag;
    logic             out_valid;

    int test_count = 0;
    int fail_count = 0;

    // Expected results in the order the runs finish
    logic [DATA_W-1:0] exp_sum_q  [$];
    logic [TAG_W-1:0]  exp_tag_q  [$];
    string             exp_name_q [$];

    `include "tb_helpers.svh"

    logic [DATA_W-1:0] run_x [MAX_TERMS]; // Plain operands of the run being built
    logic [DATA_W-1:0] run_y [MAX_TERMS];

    masked_dot_top #(
        .SEED      (32'h5a3c_96e1),
        .MULT_LAT  (2)
    ) DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .zeroize   (zeroize),
        .in_x      (in_x),
        .in_y      (in_y),
        .in_ctrl   (in_ctrl),
        .out_sum   (out_sum),
        .out_tag   (out_tag),
        .out_valid (out_valid)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk; // 20 ns period
    end

    // ==============================
    // Stimulus tasks
    // ==============================
    // Drives run_x and run_y as one run, with optional idle gaps between terms
    task automatic drive_run(input int n, input logic [TAG_W-1:0] tag, input bit idles,
                             input bit expect_result, input string name);
        share_pair_t px;
        share_pair_t py;
        int          gap;
        for (int i = 0; i < n; i++) begin
            if (idles && i > 0) begin
                gap = int'(take_bits(2)); // Zero to three idle cycles
                repeat (gap) begin
                    @(negedge clk);
                    in_ctrl = '0;
                    in_x    = share_pair_t'(take_bits(32)); // Junk data that must be ignored
                end
            end
            @(negedge clk);
            split_shares(run_x[i], px);
            split_shares(run_y[i], py);
            in_x    = px;
            in_y    = py;
            in_ctrl = '{valid: 1'b1, start: (i == 0), last: (i == n - 1), tag: tag};
        end
        if (expect_result) begin
            exp_sum_q.push_back(dot_ref(run_x, run_y, n));
            exp_tag_q.push_back(tag);
            exp_name_q.push_back(name);
        end
    endtask

    task automatic go_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            in_ctrl = '0;
        end
    endtask

    // Idles until every expected result has been seen, or gives up
    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_sum_q.size() != 0 && waited < TIMEOUT) begin
            @(negedge clk);
            in_ctrl = '0;
            waited++;
        end
        if (exp_sum_q.size() != 0) begin
            $display("Timed out waiting for %0d outstanding results", exp_sum_q.size());
            fail_count++;
        end
    endtask

    // ==============================
    // Result checker
    // ==============================
    initial begin : result_checker
        logic [DATA_W-1:0] got;
        int                idle_wait;
        bit                timed_out;
        idle_wait = 0;
        timed_out = 1'b0;
        while (!timed_out) begin
            @(negedge clk); // Outputs are stable half a cycle after the edge
            if (out_valid) begin
                idle_wait = 0;
                got       = out_sum.s0 + out_sum.s1; // Recombine the two shares
                test_count++;
                if (exp_sum_q.size() == 0) begin
                    $display("Result pulse with tag %h arrived when none was expected", out_tag);
                    fail_count++;
                end else begin
                    if (got !== exp_sum_q[0] || out_tag !== exp_tag_q[0]) begin
                        $display("FAIL %s expected sum %h tag %h actual sum %h tag %h",
                                 exp_name_q[0], exp_sum_q[0], exp_tag_q[0], got, out_tag);
                        fail_count++;
                    end else begin
                        $display("PASS %s sum %h tag %h", exp_name_q[0], got, out_tag);
                    end
                    void'(exp_sum_q.pop_front());
                    void'(exp_tag_q.pop_front());
                    void'(exp_name_q.pop_front());
                end
            end else if (exp_sum_q.size() != 0) begin
                idle_wait++;
                timed_out = (idle_wait > TIMEOUT);
            end else begin
                idle_wait = 0;
            end
        end
        $display("Timed out after %0d cycles waiting for the result of %s", TIMEOUT,
                 exp_name_q[0]);
        $display("Counts: %0d checks, %0d failed", test_count, fail_count + 1);
        $display("SOME TESTS FAILED");
        $finish;
    end

    // ==============================
    // Test sequence
    // ==============================
    initial begin : stimulus
        int n;
        int lat;
        rst_n   = 1'b0;
        zeroize = 1'b0;
        in_x    = '0;
        in_y    = '0;
        in_ctrl = '0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;

        @(negedge clk);
        test_count++;
        if (out_valid !== 1'b0 || out_sum !== '0) begin
            $display("FAIL reset_state expected valid 0 sum %h actual valid %b sum %h",
                     32'h0, out_valid, out_sum);
            fail_count++;
        end else begin
            $display("PASS reset_state");
        end

        // One-term run, out_valid must rise three edges after the input edge
        run_x[0] = rand_word();
        run_y[0] = rand_word();
        drive_run(1, 4'h1, 1'b0, 1'b1, "one_term");
        lat = 0;
        do begin
            @(negedge clk);
            in_ctrl = '0;
            lat++;
        end while (out_valid !== 1'b1 && lat < TIMEOUT);
        test_count++;
        if (out_valid !== 1'b1) begin
            $display("No result pulse within %0d cycles of the one-term run", TIMEOUT);
            fail_count++;
        end else if (lat - 1 != 3) begin
            $display("FAIL one_term_latency expected %0d actual %0d", 3, lat - 1);
            fail_count++;
        end else begin
            $display("PASS one_term_latency");
        end
        wait_drain();

        for (int r = 0; r < 20; r++) begin // Back to back, start follows last directly
            n = 1 + int'(take_bits(3));
            for (int i = 0; i < n; i++) begin
                run_x[i] = rand_word();
                run_y[i] = rand_word();
            end
            drive_run(n, TAG_W'(r), 1'b0, 1'b1, $sformatf("random_run_%0d", r));
        end
        wait_drain();

        for (int r = 0; r < 12; r++) begin
            n = 1 + int'(take_bits(3));
            for (int i = 0; i < n; i++) begin
                run_x[i] = rand_word();
                run_y[i] = rand_word();
            end
            drive_run(n, TAG_W'(r + 3), 1'b1, 1'b1, $sformatf("idle_run_%0d", r));
        end
        wait_drain();

        // The last term is still inside the multiplier when zeroize arrives
        for (int i = 0; i < 4; i++) begin
            run_x[i] = rand_word();
            run_y[i] = rand_word();
        end
        drive_run(4, 4'hd, 1'b0, 1'b0, "aborted_run");
        @(negedge clk);
        in_ctrl = '0;
        zeroize = 1'b1;
        @(negedge clk);
        zeroize = 1'b0;
        test_count++;
        if (out_valid !== 1'b0 || out_sum !== '0) begin
            $display("FAIL zeroize_clear expected valid 0 sum %h actual valid %b sum %h",
                     32'h0, out_valid, out_sum);
            fail_count++;
        end else begin
            $display("PASS zeroize_clear");
        end
        go_idle(6);                        // A stray pulse here is caught by the checker
        n = 3;
        for (int i = 0; i < n; i++) begin
            run_x[i] = rand_word();
            run_y[i] = rand_word();
        end
        drive_run(n, 4'he, 1'b0, 1'b1, "after_zeroize");
        wait_drain();

        // Products and sums that wrap past 2^16
        run_x[0] = 16'hffff;
        run_y[0] = 16'hffff;
        run_x[1] = 16'hffff;
        run_y[1] = 16'h0001;
        run_x[2] = 16'h0000;
        run_y[2] = 16'hffff;
        run_x[3] = 16'h8000;
        run_y[3] = 16'h0002;
        drive_run(4, 4'h7, 1'b0, 1'b1, "wrap_run");
        drive_run(1, 4'h8, 1'b0, 1'b1, "wrap_one_term");
        wait_drain();
        go_idle(4);

        $display("Counts: %0d checks, %0d failed", test_count, fail_count);
        if (fail_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- src.f
+incdir+verification
common/masked_types_pkg.sv
common/mac_ctrl_pkg.sv
hdl/masked_mult/masked_mult_two_share.sv
hdl/pipe_delay.sv
hdl/mask_prng.sv
hdl/masked_accum/masked_accum.sv
hdl/masked_dot_top.sv
verification/tb_masked_dot.sv
